// ==== common/spu_odd_pkg.sv ====
`default_nettype none

package spu_odd_pkg;

  // result pipe depth between execute and writeback
  localparam int pipe_depth = 7;

  // local store size in quadwords, 32 KB
  localparam int ls_quads = 2048;

  // full register value
  // byte 0 is the msb, word 0 (preferred slot) is bits 127:96
  typedef logic [127:0] quad_t;

  // register number, 128 registers
  typedef logic [6:0] reg_idx_t;

  // instruction word address
  typedef logic [9:0] pc_t;

  // local store byte address
  typedef logic [14:0] ls_addr_t;

  // raw immediate field
  // each unit slices out what it needs
  typedef logic [15:0] imm_t;

  // odd pipe operations
  typedef enum logic [3:0] {
    op_nop,
    op_fsmbi,
    op_shlqbyi,
    op_rotqbyi,
    op_rotqby,
    op_shufb,
    op_br,
    op_bra,
    op_brsl,
    op_brz,
    op_lqd,
    op_stqd,
    op_lqa,
    op_stqa
  } odd_op_e;

  // decoded instruction on the issue port
  typedef struct packed {
    odd_op_e  op;
    reg_idx_t rt;
    reg_idx_t ra;
    reg_idx_t rb;
    reg_idx_t rc;
    imm_t     imm;
  } issue_t;

  // fetched operands
  // rc_val holds rt contents for stqd, stqa and brz
  typedef struct packed {
    quad_t ra_val;
    quad_t rb_val;
    quad_t rc_val;
    imm_t  imm;
  } oper_t;

  // one result pipe stage
  typedef struct packed {
    logic     valid;
    logic     wr_en;
    reg_idx_t rt;
    quad_t    data;
  } pipe_entry_t;

  // register file write port
  typedef struct packed {
    logic     en;
    reg_idx_t addr;
    quad_t    data;
  } wb_t;

endpackage

`default_nettype wire

// ==== odd_pipe/perm_unit.sv ====
`default_nettype none

module perm_unit (
  input  spu_odd_pkg::odd_op_e op,
  input  spu_odd_pkg::oper_t   oper,
  output spu_odd_pkg::quad_t   result
);

  // rotate left by whole bytes, count 0..15
  function automatic spu_odd_pkg::quad_t rotl_bytes(input spu_odd_pkg::quad_t val,
                                                    input logic [3:0] cnt);
    logic [7:0] bits;
    bits = {1'b0, cnt, 3'b000};
    // zero count shifts right by 128, which yields 0
    return (val << bits) | (val >> (8'd128 - bits));
  endfunction

  spu_odd_pkg::quad_t fsm_res;
  spu_odd_pkg::quad_t shl_res;
  spu_odd_pkg::quad_t shuf_res;
  logic [255:0]       shuf_src;

  // fsmbi: imm bit 15 maps to byte 0
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      fsm_res[127-8*i -: 8] = {8{oper.imm[15-i]}};
    end
  end

  // shlqbyi with zero fill, counts of 16 and up clear everything
  assign shl_res = oper.imm[4] ? '0 : (oper.ra_val << {oper.imm[3:0], 3'b000});

  // shufb source bytes 0..31 are ra then rb
  assign shuf_src = {oper.ra_val, oper.rb_val};

  always_comb begin
    logic [7:0] ctl;
    for (int i = 0; i < 16; i++) begin
      ctl = oper.rc_val[127-8*i -: 8];
      // special codes first, then byte select
      if (ctl[7:6] == 2'b10) begin
        shuf_res[127-8*i -: 8] = 8'h00;
      end else if (ctl[7:5] == 3'b110) begin
        shuf_res[127-8*i -: 8] = 8'hff;
      end else if (ctl[7:5] == 3'b111) begin
        shuf_res[127-8*i -: 8] = 8'h80;
      end else begin
        shuf_res[127-8*i -: 8] = shuf_src[255-8*ctl[4:0] -: 8];
      end
    end
  end

  always_comb begin
    case (op)
      spu_odd_pkg::op_fsmbi:   result = fsm_res;
      spu_odd_pkg::op_shlqbyi: result = shl_res;
      spu_odd_pkg::op_rotqbyi: result = rotl_bytes(oper.ra_val, oper.imm[3:0]);
      // count from the low nibble of ra word 0
      spu_odd_pkg::op_rotqby:  result = rotl_bytes(oper.ra_val, oper.ra_val[99:96]);
      spu_odd_pkg::op_shufb:   result = shuf_res;
      default:                 result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== odd_pipe/branch_unit.sv ====
`default_nettype none

module branch_unit (
  input  spu_odd_pkg::odd_op_e op,
  input  spu_odd_pkg::pc_t     pc,
  input  spu_odd_pkg::oper_t   oper,
  output spu_odd_pkg::pc_t     next_pc,
  output spu_odd_pkg::quad_t   link
);

  spu_odd_pkg::pc_t seq_pc;
  spu_odd_pkg::pc_t rel_pc;
  logic             rc_zero;

  // fall-through address
  assign seq_pc = pc + 10'd1;

  // relative target, wraps at 1024 words
  assign rel_pc = pc + oper.imm[9:0];

  // brz tests the preferred slot of rt
  assign rc_zero = (oper.rc_val[127:96] == 32'd0);

  always_comb begin
    case (op)
      spu_odd_pkg::op_br:   next_pc = rel_pc;
      spu_odd_pkg::op_brsl: next_pc = rel_pc;
      // absolute target
      spu_odd_pkg::op_bra:  next_pc = oper.imm[9:0];
      spu_odd_pkg::op_brz: begin
        if (rc_zero) begin
          next_pc = rel_pc;
        end else begin
          next_pc = seq_pc;
        end
      end
      // everything else just steps
      default:              next_pc = seq_pc;
    endcase
  end

  // return address in word 0, rest zero
  // only brsl writes it back
  assign link = {22'd0, seq_pc, 96'd0};

endmodule

`default_nettype wire

// ==== odd_pipe/local_store.sv ====
`default_nettype none

module local_store (
  input  logic                 clk,
  input  spu_odd_pkg::odd_op_e op,
  input  logic                 valid,
  input  spu_odd_pkg::oper_t   oper,
  output spu_odd_pkg::quad_t   load_data
);

  // quadword array, no reset
  spu_odd_pkg::quad_t mem [spu_odd_pkg::ls_quads];

  spu_odd_pkg::ls_addr_t addr;
  logic [31:0]           d_off;
  logic                  is_store;

  // d-form offset
  // sign-extended imm[9:0], in quadwords
  assign d_off = {{18{oper.imm[9]}}, oper.imm[9:0], 4'b0000};

  // byte address, wraps to 15 bits
  always_comb begin
    case (op)
      spu_odd_pkg::op_lqd,
      spu_odd_pkg::op_stqd: begin
        // base from ra preferred slot
        addr = spu_odd_pkg::ls_addr_t'(oper.ra_val[127:96] + d_off);
      end
      spu_odd_pkg::op_lqa,
      spu_odd_pkg::op_stqa: begin
        // a-form, word immediate
        addr = spu_odd_pkg::ls_addr_t'({oper.imm, 2'b00});
      end
      default: begin
        addr = '0;
      end
    endcase
  end

  // only a live slot may write
  assign is_store = valid &&
                    ((op == spu_odd_pkg::op_stqd) || (op == spu_odd_pkg::op_stqa));

  // store data is rt, carried on rc_val
  // low 4 address bits drop, quadword aligned
  always_ff @(posedge clk) begin
    if (is_store) begin
      mem[addr[14:4]] <= oper.rc_val;
    end
  end

  // combinational read
  assign load_data = mem[addr[14:4]];

endmodule

`default_nettype wire

// ==== odd_pipe/odd_pipe.sv ====
`default_nettype none

module odd_pipe (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     valid,
  input  spu_odd_pkg::odd_op_e     op,
  input  spu_odd_pkg::reg_idx_t    rt,
  input  spu_odd_pkg::pc_t         pc,
  input  spu_odd_pkg::oper_t       oper,
  output spu_odd_pkg::pc_t         next_pc,
  output spu_odd_pkg::pipe_entry_t stages [spu_odd_pkg::pipe_depth],
  output spu_odd_pkg::wb_t         wb
);

  spu_odd_pkg::quad_t       perm_res;
  spu_odd_pkg::quad_t       link_val;
  spu_odd_pkg::quad_t       load_val;
  spu_odd_pkg::quad_t       unit_res;
  logic                     wr_en;
  spu_odd_pkg::pipe_entry_t entry;

  perm_unit u_perm (
    .op     (op),
    .oper   (oper),
    .result (perm_res)
  );

  branch_unit u_branch (
    .op      (op),
    .pc      (pc),
    .oper    (oper),
    .next_pc (next_pc),
    .link    (link_val)
  );

  local_store u_ls (
    .clk       (clk),
    .op        (op),
    .valid     (valid),
    .oper      (oper),
    .load_data (load_val)
  );

  // pick result by op class
  // stores and plain branches carry no register write
  always_comb begin
    unit_res = perm_res;
    wr_en    = 1'b0;
    case (op)
      spu_odd_pkg::op_fsmbi,
      spu_odd_pkg::op_shlqbyi,
      spu_odd_pkg::op_rotqbyi,
      spu_odd_pkg::op_rotqby,
      spu_odd_pkg::op_shufb: begin
        unit_res = perm_res;
        wr_en    = 1'b1;
      end
      spu_odd_pkg::op_lqd,
      spu_odd_pkg::op_lqa: begin
        unit_res = load_val;
        wr_en    = 1'b1;
      end
      // link register write
      spu_odd_pkg::op_brsl: begin
        unit_res = link_val;
        wr_en    = 1'b1;
      end
      default: begin
        wr_en = 1'b0;
      end
    endcase
  end

  assign entry = '{valid: valid, wr_en: wr_en, rt: rt, data: unit_res};

  // seven delay stages then the writeback register
  // stage 0 is the newest, the top level forwards from these
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < spu_odd_pkg::pipe_depth; i++) begin
        stages[i] <= '0;
      end
      wb <= '0;
    end else begin
      stages[0] <= entry;
      for (int i = 1; i < spu_odd_pkg::pipe_depth; i++) begin
        stages[i] <= stages[i-1];
      end
      wb.en   <= stages[spu_odd_pkg::pipe_depth-1].valid &&
                 stages[spu_odd_pkg::pipe_depth-1].wr_en;
      wb.addr <= stages[spu_odd_pkg::pipe_depth-1].rt;
      wb.data <= stages[spu_odd_pkg::pipe_depth-1].data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`default_nettype none

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  spu_odd_pkg::reg_idx_t ra_idx,
  input  spu_odd_pkg::reg_idx_t rb_idx,
  input  spu_odd_pkg::reg_idx_t rc_idx,
  output spu_odd_pkg::quad_t    ra_val,
  output spu_odd_pkg::quad_t    rb_val,
  output spu_odd_pkg::quad_t    rc_val,
  input  spu_odd_pkg::wb_t      wb
);

  // 128 general registers
  // no hardwired zero register
  spu_odd_pkg::quad_t regs [128];

  // single write port from the writeback register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 128; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // three async read ports
  // a same-cycle write shows up next cycle, bypass covers the gap
  assign ra_val = regs[ra_idx];
  assign rb_val = regs[rb_idx];
  assign rc_val = regs[rc_idx];

endmodule

`default_nettype wire

// ==== hw/spu_odd_top.sv ====
`default_nettype none

module spu_odd_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                issue_req,
  input  spu_odd_pkg::issue_t issue,
  output logic                issue_ack,
  output spu_odd_pkg::wb_t    wb,
  output spu_odd_pkg::pc_t    pc
);

  logic                     accept;
  logic                     slot_valid;
  spu_odd_pkg::issue_t      slot;
  spu_odd_pkg::reg_idx_t    rc_idx;
  spu_odd_pkg::quad_t       rf_ra;
  spu_odd_pkg::quad_t       rf_rb;
  spu_odd_pkg::quad_t       rf_rc;
  spu_odd_pkg::oper_t       oper;
  spu_odd_pkg::pc_t         next_pc;
  spu_odd_pkg::pipe_entry_t stages [spu_odd_pkg::pipe_depth];

  // four-phase handshake
  // take on req high with ack low, drop ack once req falls
  assign accept = issue_req && !issue_ack;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      issue_ack  <= 1'b0;
      slot_valid <= 1'b0;
      slot       <= '0;
      pc         <= '0;
    end else begin
      if (accept) begin
        issue_ack <= 1'b1;
      end else if (!issue_req) begin
        issue_ack <= 1'b0;
      end
      // slot is live for one cycle only
      slot_valid <= accept;
      if (accept) begin
        slot <= issue;
      end
      // pc steps with each executed instruction
      if (slot_valid) begin
        pc <= next_pc;
      end
    end
  end

  // stores and brz read rt through the rc port
  assign rc_idx = ((slot.op == spu_odd_pkg::op_stqd) || (slot.op == spu_odd_pkg::op_stqa) ||
                   (slot.op == spu_odd_pkg::op_brz)) ? slot.rt : slot.rc;

  reg_file u_rf (
    .clk    (clk),
    .rst    (rst),
    .ra_idx (slot.ra),
    .rb_idx (slot.rb),
    .rc_idx (rc_idx),
    .ra_val (rf_ra),
    .rb_val (rf_rb),
    .rc_val (rf_rc),
    .wb     (wb)
  );

  // operand fetch in the slot cycle
  // newest in-flight write wins, then wb, then the register file
  always_comb begin
    oper.ra_val = rf_ra;
    oper.rb_val = rf_rb;
    oper.rc_val = rf_rc;
    oper.imm    = slot.imm;
    // wb is older than any stage
    if (wb.en) begin
      if (wb.addr == slot.ra) begin
        oper.ra_val = wb.data;
      end
      if (wb.addr == slot.rb) begin
        oper.rb_val = wb.data;
      end
      if (wb.addr == rc_idx) begin
        oper.rc_val = wb.data;
      end
    end
    // walk oldest to newest so the newest match lands last
    for (int i = spu_odd_pkg::pipe_depth - 1; i >= 0; i--) begin
      if (stages[i].valid && stages[i].wr_en) begin
        if (stages[i].rt == slot.ra) begin
          oper.ra_val = stages[i].data;
        end
        if (stages[i].rt == slot.rb) begin
          oper.rb_val = stages[i].data;
        end
        if (stages[i].rt == rc_idx) begin
          oper.rc_val = stages[i].data;
        end
      end
    end
  end

  odd_pipe u_odd (
    .clk     (clk),
    .rst     (rst),
    .valid   (slot_valid),
    .op      (slot.op),
    .rt      (slot.rt),
    .pc      (pc),
    .oper    (oper),
    .next_pc (next_pc),
    .stages  (stages),
    .wb      (wb)
  );

endmodule

`default_nettype wire

// ==== sim/tb_spu_odd.sv ====
`default_nettype none

module tb_spu_odd;

  logic                clk;
  logic                rst;
  logic                issue_req;
  spu_odd_pkg::issue_t issue;
  logic                issue_ack;
  spu_odd_pkg::wb_t    wb;
  spu_odd_pkg::pc_t    pc;

  // stimulus table
  // expected fields filled in by the model
  spu_odd_pkg::issue_t   tab_issue [$];
  string                 tab_name [$];
  logic                  tab_wb [$];
  spu_odd_pkg::reg_idx_t tab_rt [$];
  spu_odd_pkg::quad_t    tab_data [$];
  spu_odd_pkg::pc_t      tab_pc [$];

  // reference state
  spu_odd_pkg::quad_t model_regs [128];
  spu_odd_pkg::quad_t model_ls [spu_odd_pkg::ls_quads];
  spu_odd_pkg::pc_t   model_pc;
  logic [31:0]        lcg_state;

  // writebacks still owed
  // table index and accept cycle
  int pend_idx [$];
  int pend_cyc [$];

  int   errors;
  int   cycle;
  int   cur_idx;
  int   accepts;
  int   ack_rises;
  logic ack_prev;
  logic timed_out;

  spu_odd_top DUT (
    .clk       (clk),
    .rst       (rst),
    .issue_req (issue_req),
    .issue     (issue),
    .issue_ack (issue_ack),
    .wb        (wb),
    .pc        (pc)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // byte 0 is the msb
  function automatic logic [7:0] byte_at(input spu_odd_pkg::quad_t q, input int i);
    return q[127-8*i -: 8];
  endfunction

  function automatic logic [7:0] shuffle_byte(input logic [7:0] ctl,
                                              input spu_odd_pkg::quad_t a,
                                              input spu_odd_pkg::quad_t b);
    return (ctl[7:6] == 2'b10) ? 8'h00 :
           (ctl[7:5] == 3'b110) ? 8'hff :
           (ctl[7:5] == 3'b111) ? 8'h80 :
           ctl[4] ? byte_at(b, ctl[3:0]) : byte_at(a, ctl[3:0]);
  endfunction

  // d-form quadword index
  function automatic int d_quad(input logic [31:0] base, input spu_odd_pkg::imm_t imm);
    logic [31:0] off;
    logic [14:0] addr;
    off  = {{22{imm[9]}}, imm[9:0]};
    addr = 15'(base + (off << 4));
    return addr[14:4];
  endfunction

  // a-form quadword index
  function automatic int a_quad(input spu_odd_pkg::imm_t imm);
    logic [14:0] addr;
    addr = 15'(imm * 4);
    return addr[14:4];
  endfunction

  task automatic check_equal(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    assert (exp === act) else begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic add_test(input string name, input spu_odd_pkg::odd_op_e op,
                          input spu_odd_pkg::reg_idx_t rt, input spu_odd_pkg::reg_idx_t ra,
                          input spu_odd_pkg::reg_idx_t rb, input spu_odd_pkg::reg_idx_t rc,
                          input spu_odd_pkg::imm_t imm);
    spu_odd_pkg::issue_t ins;
    ins.op  = op;
    ins.rt  = rt;
    ins.ra  = ra;
    ins.rb  = rb;
    ins.rc  = rc;
    ins.imm = imm;
    tab_issue.push_back(ins);
    tab_name.push_back(name);
    tab_wb.push_back(1'b0);
    tab_rt.push_back(rt);
    tab_data.push_back('0);
    tab_pc.push_back('0);
  endtask

  task automatic build_table();
    // masks, then shifts and rotates on them
    add_test("fsmbi_1", spu_odd_pkg::op_fsmbi, 1, 0, 0, 0, lcg_next());
    add_test("fsmbi_2", spu_odd_pkg::op_fsmbi, 2, 0, 0, 0, lcg_next());
    add_test("shlqbyi_3", spu_odd_pkg::op_shlqbyi, 3, 1, 0, 0, 3);
    add_test("shlqbyi_16", spu_odd_pkg::op_shlqbyi, 4, 2, 0, 0, 16);
    add_test("shlqbyi_31", spu_odd_pkg::op_shlqbyi, 5, 1, 0, 0, 31);
    add_test("rotqbyi_5", spu_odd_pkg::op_rotqbyi, 6, 3, 0, 0, 5);
    add_test("rotqbyi_23", spu_odd_pkg::op_rotqbyi, 7, 2, 0, 0, 23);
    // branches
    // brsl links give the odd bytes the shuffles need
    add_test("bra", spu_odd_pkg::op_bra, 0, 0, 0, 0, 16'h0012);
    add_test("brsl_a", spu_odd_pkg::op_brsl, 30, 0, 0, 0, 16'h00b2);
    add_test("brsl_wrap", spu_odd_pkg::op_brsl, 31, 0, 0, 0, 16'h0340);
    add_test("br_back", spu_odd_pkg::op_br, 0, 0, 0, 0, 16'h03fe);
    add_test("brz_taken", spu_odd_pkg::op_brz, 4, 0, 0, 0, 16'h0010);
    add_test("brz_not", spu_odd_pkg::op_brz, 30, 0, 0, 0, 16'h0010);
    add_test("rotqby_3", spu_odd_pkg::op_rotqby, 8, 30, 0, 0, 0);
    add_test("rotqby_5", spu_odd_pkg::op_rotqby, 9, 31, 0, 0, 0);
    add_test("rotqbyi_l1", spu_odd_pkg::op_rotqbyi, 10, 30, 0, 0, 3);
    add_test("rotqbyi_l2", spu_odd_pkg::op_rotqbyi, 11, 31, 0, 0, 3);
    // shuffle controls built from lcg masks
    add_test("shufb_ra", spu_odd_pkg::op_shufb, 12, 10, 31, 1, 0);
    add_test("shufb_rb", spu_odd_pkg::op_shufb, 13, 10, 31, 12, 0);
    add_test("shufb_sel", spu_odd_pkg::op_shufb, 14, 11, 1, 2, 0);
    add_test("shufb_ff", spu_odd_pkg::op_shufb, 15, 1, 2, 14, 0);
    // local store round trips
    // two of them wrap
    add_test("stqd_wrap", spu_odd_pkg::op_stqd, 13, 4, 0, 0, 16'h03ff);
    add_test("stqa_wrap", spu_odd_pkg::op_stqa, 15, 0, 0, 0, 16'h2004);
    add_test("stqd_base", spu_odd_pkg::op_stqd, 9, 30, 0, 0, 16'h0020);
    add_test("lqd_wrap", spu_odd_pkg::op_lqd, 16, 4, 0, 0, 16'h03ff);
    add_test("lqa_wrap", spu_odd_pkg::op_lqa, 17, 0, 0, 0, 16'h2004);
    add_test("lqd_base", spu_odd_pkg::op_lqd, 18, 30, 0, 0, 16'h0020);
    add_test("lqa_base", spu_odd_pkg::op_lqa, 19, 0, 0, 0, 16'h0084);
    // dependent chain through the bypass
    add_test("fsmbi_3", spu_odd_pkg::op_fsmbi, 20, 0, 0, 0, lcg_next());
    add_test("rotqbyi_dep", spu_odd_pkg::op_rotqbyi, 20, 20, 0, 0, 1);
    add_test("shufb_dep", spu_odd_pkg::op_shufb, 21, 20, 13, 20, 0);
    add_test("stqa_dep", spu_odd_pkg::op_stqa, 21, 0, 0, 0, 16'h0100);
    add_test("lqa_dep", spu_odd_pkg::op_lqa, 22, 0, 0, 0, 16'h0100);
    add_test("shlqbyi_dep", spu_odd_pkg::op_shlqbyi, 22, 22, 0, 0, 2);
    add_test("rotqby_dep", spu_odd_pkg::op_rotqby, 23, 22, 0, 0, 0);
  endtask

  // in-order model of one instruction
  task automatic predict(input int k);
    spu_odd_pkg::issue_t ins;
    spu_odd_pkg::quad_t  a;
    spu_odd_pkg::quad_t  r;
    spu_odd_pkg::pc_t    seq;
    logic [31:0]         w0;
    int                  n;
    ins       = tab_issue[k];
    a         = model_regs[ins.ra];
    w0        = a[127:96];
    seq       = model_pc + 10'd1;
    r         = '0;
    tab_wb[k] = 1'b1;
    tab_pc[k] = seq;
    case (ins.op)
      spu_odd_pkg::op_fsmbi: begin
        for (int i = 0; i < 16; i++) begin
          r = (r << 8) | (ins.imm[15-i] ? 128'hff : 128'h0);
        end
      end
      spu_odd_pkg::op_shlqbyi: begin
        n = ins.imm[4:0];
        for (int i = 0; i < 16; i++) begin
          r = (r << 8) | ((i + n < 16) ? byte_at(a, i + n) : 8'h00);
        end
      end
      spu_odd_pkg::op_rotqbyi,
      spu_odd_pkg::op_rotqby: begin
        n = (ins.op == spu_odd_pkg::op_rotqby) ? w0[3:0] : ins.imm[3:0];
        for (int i = 0; i < 16; i++) begin
          r = (r << 8) | byte_at(a, (i + n) % 16);
        end
      end
      spu_odd_pkg::op_shufb: begin
        for (int i = 0; i < 16; i++) begin
          r = (r << 8) | shuffle_byte(byte_at(model_regs[ins.rc], i), a, model_regs[ins.rb]);
        end
      end
      spu_odd_pkg::op_br: begin
        tab_wb[k] = 1'b0;
        tab_pc[k] = model_pc + ins.imm[9:0];
      end
      spu_odd_pkg::op_bra: begin
        tab_wb[k] = 1'b0;
        tab_pc[k] = ins.imm[9:0];
      end
      spu_odd_pkg::op_brsl: begin
        tab_pc[k]  = model_pc + ins.imm[9:0];
        r[127:96] = 32'(seq);
      end
      spu_odd_pkg::op_brz: begin
        tab_wb[k] = 1'b0;
        if (model_regs[ins.rt][127:96] == 32'd0) begin
          tab_pc[k] = model_pc + ins.imm[9:0];
        end
      end
      spu_odd_pkg::op_lqd: r = model_ls[d_quad(w0, ins.imm)];
      spu_odd_pkg::op_lqa: r = model_ls[a_quad(ins.imm)];
      spu_odd_pkg::op_stqd: begin
        tab_wb[k]                    = 1'b0;
        model_ls[d_quad(w0, ins.imm)] = model_regs[ins.rt];
      end
      spu_odd_pkg::op_stqa: begin
        tab_wb[k]                  = 1'b0;
        model_ls[a_quad(ins.imm)] = model_regs[ins.rt];
      end
      default: tab_wb[k] = 1'b0;
    endcase
    tab_data[k] = r;
    if (tab_wb[k]) begin
      model_regs[ins.rt] = r;
    end
    model_pc = tab_pc[k];
  endtask

  // samples pre-edge values
  // gives up after 64 cycles
  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    if (!timed_out) begin
      @(posedge clk);
      while (issue_ack !== level && n < 64) begin
        @(posedge clk);
        n++;
      end
      assert (issue_ack === level) else begin
        errors++;
        timed_out = 1'b1;
        $display("timeout while waiting for issue_ack to become %0b", level);
      end
    end
  endtask

  task automatic check_writeback();
    int k;
    int c;
    assert (pend_idx.size() > 0) else begin
      errors++;
      $display("writeback to r%0d arrived when none was expected", wb.addr);
    end
    if (pend_idx.size() > 0) begin
      k = pend_idx.pop_front();
      c = pend_cyc.pop_front();
      check_equal({tab_name[k], " rt"}, tab_rt[k], wb.addr);
      check_equal({tab_name[k], " data"}, tab_data[k], wb.data);
      // wb register loads 8 edges after accept and is seen one edge later
      check_equal({tab_name[k], " latency"}, 128'd8, cycle - c - 1);
    end
  endtask

  // accept and writeback monitor
  always @(posedge clk) begin
    cycle++;
    if (!rst) begin
      if (issue_req && !issue_ack) begin
        accepts++;
        if (tab_wb[cur_idx]) begin
          pend_idx.push_back(cur_idx);
          pend_cyc.push_back(cycle);
        end
      end
      if (issue_ack && !ack_prev) begin
        ack_rises++;
      end
      if (wb.en) begin
        check_writeback();
      end
    end
    ack_prev = issue_ack;
  end

  initial begin
    int n;
    rst       = 1'b1;
    issue_req = 1'b0;
    issue     = '0;
    errors    = 0;
    cycle     = 0;
    cur_idx   = 0;
    accepts   = 0;
    ack_rises = 0;
    ack_prev  = 1'b0;
    timed_out = 1'b0;
    lcg_state = 32'd97;
    model_pc  = '0;
    for (int i = 0; i < 128; i++) begin
      model_regs[i] = '0;
    end
    build_table();
    for (int k = 0; k < tab_issue.size(); k++) begin
      predict(k);
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_equal("reset ack", 1'b0, issue_ack);
    check_equal("reset wb_en", 1'b0, wb.en);
    check_equal("reset pc", 10'd0, pc);
    // four-phase handshake at full rate
    for (int k = 0; k < tab_issue.size() && !timed_out; k++) begin
      issue     <= tab_issue[k];
      issue_req <= 1'b1;
      cur_idx   = k;
      wait_ack(1'b1);
      issue_req <= 1'b0;
      wait_ack(1'b0);
      if (!timed_out) begin
        check_equal({tab_name[k], " pc"}, tab_pc[k], pc);
      end
    end
    n = 0;
    while (pend_idx.size() > 0 && n < 64) begin
      @(posedge clk);
      n++;
    end
    assert (pend_idx.size() == 0) else begin
      errors++;
      $display("%0d expected writebacks never arrived", pend_idx.size());
    end
    // room for a stray writeback to show up
    repeat (spu_odd_pkg::pipe_depth + 3) @(posedge clk);
    check_equal("accept count", tab_issue.size(), accepts);
    check_equal("ack pulses", tab_issue.size(), ack_rises);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
common/spu_odd_pkg.sv
odd_pipe/perm_unit.sv
odd_pipe/branch_unit.sv
odd_pipe/local_store.sv
odd_pipe/odd_pipe.sv
hw/reg_file.sv
hw/spu_odd_top.sv
sim/tb_spu_odd.sv
